// ==== pec.f ====
+incdir+rtl
rtl/pecPkg.sv
rtl/macUnit.sv
rtl/convRow.sv
rtl/wgtBank.sv
rtl/pecCtrl.sv
rtl/psumPort.sv
rtl/pecTop.sv
test/pecTb.sv

// ==== rtl/convRow.sv ====
module convRow (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  pecPkg::vecT  act,
    input  pecPkg::vecT  wgt0,
    input  pecPkg::vecT  wgt1,
    input  pecPkg::vecT  wgt2,
    output pecPkg::psumT rowSum,
    output logic         done
);

    // Per tap dot products
    pecPkg::psumT tapRes0;
    pecPkg::psumT tapRes1;
    pecPkg::psumT tapRes2;
    logic         done0;
    logic         done1;
    logic         done2;

    // Finish detection
    logic         doneD;
    logic         finish;

    // Transposed window registers
    pecPkg::psumT stage1;
    pecPkg::psumT stage2;

    // =======================================================================
    // Tap MACs, all fed with the same activation column
    // =======================================================================

    macUnit tap0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .wgt    (wgt0),
        .act    (act),
        .result (tapRes0),
        .done   (done0)
    );

    macUnit tap1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .wgt    (wgt1),
        .act    (act),
        .result (tapRes1),
        .done   (done1)
    );

    macUnit tap2 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .wgt    (wgt2),
        .act    (act),
        .result (tapRes2),
        .done   (done2)
    );

    assign done = done0 & done1 & done2;

    // Rising edge of done marks a finished item
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            doneD <= 1'b1;
        end else begin
            doneD <= done;
        end
    end

    assign finish = done & ~doneD;

    // =======================================================================
    // Sliding window along the row
    // =======================================================================

    // stage1 holds tap 0 of column c-1
    // stage2 holds tap 0 of c-2 plus tap 1 of c-1
    always_ff @(posedge clk) begin
        if (finish) begin
            stage1 <= tapRes0;
            stage2 <= stage1 + tapRes1;
        end
    end

    // Window ending at the current column, valid in the finish cycle
    assign rowSum = stage2 + tapRes2;

endmodule

// ==== rtl/macUnit.sv ====
`include "pec_cfg.svh"

module macUnit (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  pecPkg::vecT  wgt,
    input  pecPkg::vecT  act,
    output pecPkg::psumT result,
    output logic         done
);

    // =======================================================================
    // Element walk
    // =======================================================================

    logic                            busy;
    pecPkg::elemT                    elemIdx;
    pecPkg::elemT                    sel;
    pecPkg::dataT                    wgtElem;
    pecPkg::dataT                    actElem;
    logic signed [2*`DATA_WIDTH-1:0] prod;
    pecPkg::psumT                    acc;

    // Element 0 is multiplied in the start cycle itself
    assign sel     = start ? '0 : elemIdx;
    assign wgtElem = wgt[sel];
    assign actElem = act[sel];

    // Single shared signed multiplier
    assign prod = wgtElem * actElem;

    // Busy for BLOCK_DEPTH-1 cycles after start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            elemIdx <= '0;
        end else if (start) begin
            busy    <= 1'b1;
            elemIdx <= pecPkg::elemT'(1);
        end else if (busy) begin
            elemIdx <= elemIdx + pecPkg::elemT'(1);
            // Last channel reached
            if (elemIdx == pecPkg::elemT'(`BLOCK_DEPTH - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    // Accumulator, restarted with the first product
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= pecPkg::psumT'(prod);
        end else if (busy) begin
            acc <= acc + pecPkg::psumT'(prod);
        end
    end

    assign result = acc;

    // Low from the start cycle on, high again once acc holds the full dot product
    assign done = ~busy & ~start;

    // Controller only starts a new item after every MAC reported done
    assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else $error("macUnit: start received while still accumulating");

endmodule

// ==== rtl/pecCtrl.sv ====
module pecCtrl (
    input  logic        clk,
    input  logic        rst_n,
    // Weight handshake
    input  logic        wgtRdy,
    output logic        wgtGet,
    // Upstream activation
    input  logic        upRdy,
    input  pecPkg::vecT upAct,
    input  logic        upFirstRow,
    input  logic        upLastCol,
    input  logic        upLastRow,
    output logic        upGet,
    // Downstream activation
    output logic        dnRdy,
    input  logic        dnGet,
    output pecPkg::vecT dnAct,
    output logic        dnFirstRow,
    output logic        dnLastCol,
    output logic        dnLastRow,
    // MAC side
    input  logic        macDone,
    output logic        start,
    output pecPkg::colT colIdx
);

    pecPkg::ctrlStateT state;
    pecPkg::ctrlStateT nextState;

    // =======================================================================
    // State machine
    // =======================================================================

    always_comb begin
        nextState = state;
        unique case (state)
            // Load a fresh weight set
            pecPkg::WaitWgt: begin
                if (wgtRdy) begin
                    nextState = pecPkg::WaitAct;
                end
            end
            // Take the next item once all MACs are free
            pecPkg::WaitAct: begin
                if (upGet) begin
                    nextState = pecPkg::WaitFwd;
                end
            end
            // Hold the item until the next cluster took it
            pecPkg::WaitFwd: begin
                if (dnGet) begin
                    if (dnLastCol && dnLastRow) begin
                        nextState = pecPkg::EndBlk;
                    end else begin
                        nextState = pecPkg::WaitAct;
                    end
                end
            end
            // Last item still computing, weights must not change yet
            pecPkg::EndBlk: begin
                if (macDone) begin
                    nextState = pecPkg::WaitWgt;
                end
            end
        endcase
    end

    // Handshake pulses and levels
    assign wgtGet = (state == pecPkg::WaitWgt) && wgtRdy;
    assign upGet  = (state == pecPkg::WaitAct) && upRdy && macDone;
    assign dnRdy  = (state == pecPkg::WaitFwd);

    // =======================================================================
    // Held item, start pulse and column count
    // =======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= pecPkg::WaitWgt;
            start      <= 1'b0;
            dnFirstRow <= 1'b0;
            // Behaves as if a row just ended, first item gets column 0
            dnLastCol  <= 1'b1;
            dnLastRow  <= 1'b0;
            colIdx     <= '0;
        end else begin
            state <= nextState;
            // MACs start the cycle after capture
            start <= upGet;
            if (upGet) begin
                dnFirstRow <= upFirstRow;
                dnLastCol  <= upLastCol;
                dnLastRow  <= upLastRow;
                // Restart counting after the previous lastCol item
                if (dnLastCol) begin
                    colIdx <= '0;
                end else begin
                    colIdx <= colIdx + pecPkg::colT'(1);
                end
            end
        end
    end

    // Activation payload
    always_ff @(posedge clk) begin
        if (upGet) begin
            dnAct <= upAct;
        end
    end

    // Weight load and item capture are in different states
    assert property (@(posedge clk) disable iff (!rst_n) !(wgtGet && upGet))
        else $error("pecCtrl: wgtGet and upGet in the same cycle");

    // Next cluster sees a steady offer until it takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        dnRdy && !dnGet |=> dnRdy && $stable(dnAct))
        else $error("pecCtrl: downstream offer dropped or changed before dnGet");

endmodule

// ==== rtl/pecPkg.sv ====
`include "pec_cfg.svh"

package pecPkg;

    // One signed activation or weight element
    typedef logic signed [`DATA_WIDTH-1:0] dataT;

    // Channel vector, element 0 in the low bits
    typedef dataT [`BLOCK_DEPTH-1:0] vecT;

    // Full weight set, index is row * KERNEL_SIZE + tap
    typedef vecT [`KERNEL_SIZE*`KERNEL_SIZE-1:0] wgtSetT;

    // Signed partial sum
    typedef logic signed [`PSUM_WIDTH-1:0] psumT;

    // Psum RAM address
    typedef logic [`PSUM_ADDR_WIDTH-1:0] addrT;

    // Column index within one row
    typedef logic [$clog2(`ROW_LEN)-1:0] colT;

    // Channel index inside a MAC
    typedef logic [$clog2(`BLOCK_DEPTH)-1:0] elemT;

    // Controller states
    typedef enum logic [1:0] {
        WaitWgt,
        WaitAct,
        WaitFwd,
        EndBlk
    } ctrlStateT;

endpackage

// ==== rtl/pecTop.sv ====
`include "pec_cfg.svh"

module pecTop (
    input  logic           clk,
    input  logic           rst_n,
    // Weight distributor
    input  logic           wgtRdy,
    output logic           wgtGet,
    input  pecPkg::wgtSetT wgtIn,
    // Previous cluster
    input  logic           upRdy,
    input  pecPkg::vecT    upAct,
    input  logic           upFirstRow,
    input  logic           upLastCol,
    input  logic           upLastRow,
    output logic           upGet,
    // Next cluster
    output logic           dnRdy,
    input  logic           dnGet,
    output pecPkg::vecT    dnAct,
    output logic           dnFirstRow,
    output logic           dnLastCol,
    output logic           dnLastRow,
    // Psum RAM
    output logic           ramRdEn,
    output pecPkg::addrT   ramRdAddr,
    input  pecPkg::psumT   ramRdData,
    output logic           ramWrEn,
    output pecPkg::addrT   ramWrAddr,
    output pecPkg::psumT   ramWrData
);

    pecPkg::wgtSetT           wgt;
    logic                     start;
    pecPkg::colT              colIdx;
    logic [`KERNEL_SIZE-1:0]  rowDone;
    logic                     macDone;
    pecPkg::psumT             rowSum [`KERNEL_SIZE];
    logic                     rdPend;
    pecPkg::psumT             psumHold;
    pecPkg::psumT             ramPsum;
    pecPkg::psumT             total;

    // =======================================================================
    // Control and weights
    // =======================================================================

    pecCtrl ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .wgtRdy     (wgtRdy),
        .wgtGet     (wgtGet),
        .upRdy      (upRdy),
        .upAct      (upAct),
        .upFirstRow (upFirstRow),
        .upLastCol  (upLastCol),
        .upLastRow  (upLastRow),
        .upGet      (upGet),
        .dnRdy      (dnRdy),
        .dnGet      (dnGet),
        .dnAct      (dnAct),
        .dnFirstRow (dnFirstRow),
        .dnLastCol  (dnLastCol),
        .dnLastRow  (dnLastRow),
        .macDone    (macDone),
        .start      (start),
        .colIdx     (colIdx)
    );

    wgtBank bank (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (wgtGet),
        .wgtIn  (wgtIn),
        .wgtOut (wgt)
    );

    // =======================================================================
    // Kernel rows, each works on the held item
    // =======================================================================

    for (genvar k = 0; k < `KERNEL_SIZE; k++) begin : gRow
        convRow row (
            .clk    (clk),
            .rst_n  (rst_n),
            .start  (start),
            .act    (dnAct),
            .wgt0   (wgt[`KERNEL_SIZE*k]),
            .wgt1   (wgt[`KERNEL_SIZE*k+1]),
            .wgt2   (wgt[`KERNEL_SIZE*k+2]),
            .rowSum (rowSum[k]),
            .done   (rowDone[k])
        );
    end

    // All nine MACs idle
    assign macDone = &rowDone;

    // Keep the read word, RAM output is only good the cycle after ramRdEn
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdPend <= 1'b0;
        end else begin
            rdPend <= ramRdEn;
        end
    end

    always_ff @(posedge clk) begin
        if (rdPend) begin
            psumHold <= ramRdData;
        end
    end

    // Stored psum counts as zero on a first row
    assign ramPsum = dnFirstRow ? '0 : psumHold;

    // Three row windows plus the earlier partial sum
    always_comb begin
        total = ramPsum;
        for (int k = 0; k < `KERNEL_SIZE; k++) begin
            total = total + rowSum[k];
        end
    end

    psumPort port (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .firstRow  (dnFirstRow),
        .lastCol   (dnLastCol),
        .macDone   (macDone),
        .colIdx    (colIdx),
        .sum       (total),
        .ramRdEn   (ramRdEn),
        .ramRdAddr (ramRdAddr),
        .ramWrEn   (ramWrEn),
        .ramWrAddr (ramWrAddr),
        .ramWrData (ramWrData)
    );

endmodule

// ==== rtl/pec_cfg.svh ====
`ifndef PEC_CFG_SVH
`define PEC_CFG_SVH

// ===========================================================================
// Cluster dimensions
// ===========================================================================

// Width of one activation or weight element
`define DATA_WIDTH 8

// Channels per activation or weight vector
`define BLOCK_DEPTH 8

// Taps per kernel row, also the number of kernel rows
`define KERNEL_SIZE 3

// Partial sum width, wide enough for 9 dot products of 8 channels
`define PSUM_WIDTH 24

// Activation items in one row
`define ROW_LEN 16

// Psum RAM address width
`define PSUM_ADDR_WIDTH 4

`endif

// ==== rtl/psumPort.sv ====
module psumPort (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  logic         firstRow,
    input  logic         lastCol,
    input  logic         macDone,
    input  pecPkg::colT  colIdx,
    input  pecPkg::psumT sum,
    output logic         ramRdEn,
    output pecPkg::addrT ramRdAddr,
    output logic         ramWrEn,
    output pecPkg::addrT ramWrAddr,
    output pecPkg::psumT ramWrData
);

    logic doneD;
    logic finish;
    logic validCol;
    logic wrLast;

    // Columns 0 and 1 only fill the window, no output yet
    assign validCol = colIdx >= pecPkg::colT'(2);

    // =======================================================================
    // Read side
    // =======================================================================

    // First row has nothing stored yet
    assign ramRdEn = start && validCol && !firstRow;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ramRdAddr <= '0;
        end else if (finish && lastCol) begin
            ramRdAddr <= '0;
        end else if (ramRdEn) begin
            ramRdAddr <= ramRdAddr + pecPkg::addrT'(1);
        end
    end

    // =======================================================================
    // Write side
    // =======================================================================

    // Rise of the combined done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            doneD <= 1'b1;
        end else begin
            doneD <= macDone;
        end
    end

    assign finish = macDone & ~doneD;

    // Write one cycle after finish, lastCol kept since the item may be replaced
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ramWrEn <= 1'b0;
            wrLast  <= 1'b0;
        end else begin
            ramWrEn <= finish && validCol;
            if (finish) begin
                wrLast <= lastCol;
            end
        end
    end

    // Window sum is only valid in the finish cycle
    always_ff @(posedge clk) begin
        if (finish) begin
            ramWrData <= sum;
        end
    end

    // Address follows each write, back to 0 after the row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ramWrAddr <= '0;
        end else if (ramWrEn) begin
            if (wrLast) begin
                ramWrAddr <= '0;
            end else begin
                ramWrAddr <= ramWrAddr + pecPkg::addrT'(1);
            end
        end
    end

    // One write per item
    assert property (@(posedge clk) disable iff (!rst_n) ramWrEn |=> !ramWrEn)
        else $error("psumPort: ramWrEn longer than one cycle");

endmodule

// ==== rtl/wgtBank.sv ====
module wgtBank (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           load,
    input  pecPkg::wgtSetT wgtIn,
    output pecPkg::wgtSetT wgtOut
);

    // =======================================================================
    // Weight storage
    // =======================================================================

    // Nine vectors indexed by kernel row * 3 + tap
    // Row 0 sits in entries 0..2 and row 2 in entries 6..8
    // All vectors swap together so a block never sees mixed weights
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wgtOut <= '0;
        end else if (load) begin
            // Captured at the end of the wgtGet cycle
            wgtOut <= wgtIn;
        end
    end

endmodule

// ==== test/pecTb.sv ====
`include "pec_cfg.svh"

module pecTb;

    timeunit 1ns;
    timeprecision 100ps;

    // Stimulus size
    localparam int numBlk     = 2;
    localparam int numRows    = 3;
    localparam int numItems   = numBlk * numRows * `ROW_LEN;
    localparam int numOut     = `ROW_LEN - `KERNEL_SIZE + 1;
    localparam int numWrites  = numBlk * numRows * numOut;
    localparam int ramWords   = 2 ** `PSUM_ADDR_WIDTH;
    // Worst item takes BLOCK_DEPTH+6 cycles and the margin covers reset, loads and drain
    localparam int cycleLimit = numItems * (`BLOCK_DEPTH + 6) + 400;

    // Test indices
    localparam int tWgt   = 0;
    localparam int tFwd   = 1;
    localparam int tFirst = 2;
    localparam int tAccum = 3;
    localparam int tLoad  = 4;

    // DUT ports
    logic           clk;
    logic           rst_n;
    logic           wgtRdy;
    logic           wgtGet;
    pecPkg::wgtSetT wgtIn;
    logic           upRdy;
    pecPkg::vecT    upAct;
    logic           upFirstRow;
    logic           upLastCol;
    logic           upLastRow;
    logic           upGet;
    logic           dnRdy;
    logic           dnGet;
    pecPkg::vecT    dnAct;
    logic           dnFirstRow;
    logic           dnLastCol;
    logic           dnLastRow;
    logic           ramRdEn;
    pecPkg::addrT   ramRdAddr;
    pecPkg::psumT   ramRdData;
    logic           ramWrEn;
    pecPkg::addrT   ramWrAddr;
    pecPkg::psumT   ramWrData;

    // Stimulus generated up front from one seed stream
    integer         seed;
    pecPkg::wgtSetT wgtSet [numBlk];
    pecPkg::vecT    itemAct [numItems];
    logic           itemFirst [numItems];
    logic           itemLastCol [numItems];
    logic           itemLastRow [numItems];
    int             upGap [numItems];
    int             dnGap [numItems];

    // Expected RAM writes in order
    int             expAddrQ [$];
    pecPkg::psumT   expDataQ [$];
    int             expTestQ [$];

    // Psum RAM model
    pecPkg::psumT   ramMem [ramWords];
    bit             rdDue = 1'b0;
    pecPkg::addrT   rdAddr = '0;

    // Progress and results
    int             cycles = 0;
    int             fwdCount = 0;
    int             wrCount = 0;
    int             wgtLoads = 0;
    int             blocksDone = 0;
    int             capCount = 0;
    bit             wgtGetPrev = 1'b0;
    bit             upGetPrev = 1'b0;
    int             checkCount [5] = '{default: 0};
    int             errCount [5] = '{default: 0};

    pecTop DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .wgtRdy     (wgtRdy),
        .wgtGet     (wgtGet),
        .wgtIn      (wgtIn),
        .upRdy      (upRdy),
        .upAct      (upAct),
        .upFirstRow (upFirstRow),
        .upLastCol  (upLastCol),
        .upLastRow  (upLastRow),
        .upGet      (upGet),
        .dnRdy      (dnRdy),
        .dnGet      (dnGet),
        .dnAct      (dnAct),
        .dnFirstRow (dnFirstRow),
        .dnLastCol  (dnLastCol),
        .dnLastRow  (dnLastRow),
        .ramRdEn    (ramRdEn),
        .ramRdAddr  (ramRdAddr),
        .ramRdData  (ramRdData),
        .ramWrEn    (ramWrEn),
        .ramWrAddr  (ramWrAddr),
        .ramWrData  (ramWrData)
    );

    // ========================================================================
    // Helpers
    // ========================================================================

    task automatic compareValue(input int test, input string name,
                                input logic [63:0] got, input logic [63:0] exp);
        checkCount[test]++;
        assert (got === exp) else begin
            $display("error at %0d ns: %s got %h expected %h", $time, name, got, exp);
            errCount[test]++;
        end
    endtask

    task automatic requireCond(input int test, input bit ok, input string what);
        checkCount[test]++;
        assert (ok) else begin
            $display("failure at %0d ns: %s", $time, what);
            errCount[test]++;
        end
    endtask

    // Signed channel dot product
    function automatic int dotProd(pecPkg::vecT w, pecPkg::vecT a);
        int s;
        s = 0;
        for (int i = 0; i < `BLOCK_DEPTH; i++) begin
            s += int'($signed(w[i])) * int'($signed(a[i]));
        end
        return s;
    endfunction

    // Items that close a full window on a row that accumulates need the stored word
    function automatic bit readsPsum(int n);
        return (n % `ROW_LEN >= `KERNEL_SIZE - 1) && !itemFirst[n];
    endfunction

    task automatic makeStimulus();
        int n;
        for (int b = 0; b < numBlk; b++) begin
            for (int i = 0; i < `KERNEL_SIZE * `KERNEL_SIZE; i++) begin
                wgtSet[b][i] = {$random(seed), $random(seed)};
            end
        end
        n = 0;
        for (int b = 0; b < numBlk; b++) begin
            for (int r = 0; r < numRows; r++) begin
                for (int c = 0; c < `ROW_LEN; c++) begin
                    itemAct[n]     = {$random(seed), $random(seed)};
                    itemFirst[n]   = (r == 0);
                    itemLastCol[n] = (c == `ROW_LEN - 1);
                    itemLastRow[n] = (r == numRows - 1);
                    upGap[n]       = $unsigned($random(seed)) % 4;
                    // Long gaps stall the next item behind the forward
                    dnGap[n]       = $unsigned($random(seed)) % 12;
                    n++;
                end
            end
        end
    endtask

    // Reference model sums the window over rows k and taps t
    // After row 0 it adds the stored word
    task automatic buildModel();
        pecPkg::psumT refMem [numOut];
        int           base;
        int           sum;
        for (int b = 0; b < numBlk; b++) begin
            for (int r = 0; r < numRows; r++) begin
                base = (b * numRows + r) * `ROW_LEN;
                for (int x = 0; x < numOut; x++) begin
                    sum = 0;
                    for (int k = 0; k < `KERNEL_SIZE; k++) begin
                        for (int t = 0; t < `KERNEL_SIZE; t++) begin
                            sum += dotProd(wgtSet[b][`KERNEL_SIZE * k + t],
                                           itemAct[base + x + t]);
                        end
                    end
                    if (r != 0) begin
                        sum += int'(refMem[x]);
                    end
                    refMem[x] = pecPkg::psumT'(sum);
                    expAddrQ.push_back(x);
                    expDataQ.push_back(refMem[x]);
                    if (b > 0) begin
                        expTestQ.push_back(tLoad);
                    end else if (r == 0) begin
                        expTestQ.push_back(tFirst);
                    end else begin
                        expTestQ.push_back(tAccum);
                    end
                end
            end
        end
    endtask

    task automatic printTest(input int test, input string name);
        $display("test %0d %-16s checks %0d errors %0d", test + 1, name,
                 checkCount[test], errCount[test]);
    endtask

    // ========================================================================
    // Clock, reset and timeout
    // ========================================================================

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, items or writes still missing", cycles);
            $display("Something failed");
            $finish;
        end
    end

    initial begin : mainSeq
        int totalChecks;
        int totalErrs;
        seed       = 32'h8864_4d98;
        rst_n      = 1'b0;
        wgtRdy     = 1'b0;
        wgtIn      = '0;
        upRdy      = 1'b0;
        upAct      = '0;
        upFirstRow = 1'b0;
        upLastCol  = 1'b0;
        upLastRow  = 1'b0;
        dnGet      = 1'b0;
        ramRdData  = '0;
        // Stale content that every first row must ignore
        for (int a = 0; a < ramWords; a++) begin
            ramMem[a] = pecPkg::psumT'((a * 24'h01_0101) ^ 24'h5A_C3A5);
        end
        makeStimulus();
        buildModel();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        wait (fwdCount == numItems && wrCount == numWrites);
        // Room for any stray extra write or load
        repeat (20) @(negedge clk);

        requireCond(tWgt, wgtLoads == numBlk, "weight set not loaded once per block");

        printTest(tWgt, "weightHandshake");
        printTest(tFwd, "forwarding");
        printTest(tFirst, "firstRow");
        printTest(tAccum, "accumulation");
        printTest(tLoad, "blockReload");

        totalChecks = 0;
        totalErrs   = 0;
        for (int i = 0; i < 5; i++) begin
            totalChecks += checkCount[i];
            totalErrs   += errCount[i];
        end
        $display("checks %0d, errors %0d, items %0d, writes %0d",
                 totalChecks, totalErrs, fwdCount, wrCount);
        if (totalErrs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // ========================================================================
    // Drivers, all on the falling edge
    // ========================================================================

    // Next weight set offered as soon as the previous one was taken
    initial begin : wgtSide
        bit got;
        @(posedge rst_n);
        for (int b = 0; b < numBlk; b++) begin
            @(negedge clk);
            wgtRdy = 1'b1;
            wgtIn  = wgtSet[b];
            got    = 1'b0;
            while (!got) begin
                #1;
                got = wgtGet;
                @(negedge clk);
            end
            wgtRdy = 1'b0;
            wgtIn  = '0;
        end
    end

    initial begin : upSide
        bit got;
        @(posedge rst_n);
        for (int n = 0; n < numItems; n++) begin
            repeat (upGap[n]) @(negedge clk);
            @(negedge clk);
            upRdy      = 1'b1;
            upAct      = itemAct[n];
            upFirstRow = itemFirst[n];
            upLastCol  = itemLastCol[n];
            upLastRow  = itemLastRow[n];
            got        = 1'b0;
            while (!got) begin
                #1;
                got = upGet;
                @(negedge clk);
            end
            // Garbage on the bus between items
            upRdy      = 1'b0;
            upAct      = ~itemAct[n];
            upFirstRow = 1'b0;
            upLastCol  = 1'b0;
            upLastRow  = 1'b0;
        end
    end

    // Random delay before taking each offered item
    initial begin : dnSide
        int k;
        k = 0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            #1;
            if (dnRdy) begin
                repeat (k < numItems ? dnGap[k] : 0) @(negedge clk);
                @(negedge clk);
                dnGet = 1'b1;
                @(negedge clk);
                dnGet = 1'b0;
                k++;
            end
        end
    end

    // ========================================================================
    // Monitors
    // ========================================================================

    // Handshakes settle shortly after the inputs change
    always @(negedge clk) begin : handshakeMon
        bit rdExp;
        #1;
        if (rst_n) begin
            if (dnRdy && dnGet) begin
                if (fwdCount >= numItems) begin
                    requireCond(tFwd, 1'b0, "item forwarded after the last one");
                end else begin
                    compareValue(tFwd, "dnAct", dnAct, itemAct[fwdCount]);
                    compareValue(tFwd, "dnFirstRow/dnLastCol/dnLastRow",
                                 {dnFirstRow, dnLastCol, dnLastRow},
                                 {itemFirst[fwdCount], itemLastCol[fwdCount],
                                  itemLastRow[fwdCount]});
                    if (itemLastCol[fwdCount] && itemLastRow[fwdCount]) begin
                        blocksDone++;
                    end
                    fwdCount++;
                end
            end
            if (wgtGet) begin
                requireCond(tWgt, !wgtGetPrev, "wgtGet high for more than one cycle");
                requireCond(tWgt, wgtRdy, "wgtGet without wgtRdy");
                // Only after reset or after the previous block ended
                requireCond(tWgt, wgtLoads == blocksDone,
                            "weights loaded while a block was still running");
                wgtLoads++;
            end
            wgtGetPrev = wgtGet;
            // Read goes out in the start cycle right after the capture
            rdExp = upGetPrev && readsPsum(capCount - 1);
            if (ramRdEn || rdExp) begin
                compareValue(tAccum, "ramRdEn", ramRdEn, rdExp);
                if (rdExp) begin
                    compareValue(tAccum, "ramRdAddr", ramRdAddr,
                                 (capCount - 1) % `ROW_LEN - (`KERNEL_SIZE - 1));
                end
            end
            if (upGet) begin
                capCount++;
            end
            upGetPrev = upGet;
        end
    end

    // RAM model returns reads one cycle after ramRdEn and checks each write
    always @(negedge clk) begin : ramModel
        int           test;
        int           addr;
        pecPkg::psumT data;
        if (rdDue) begin
            ramRdData = ramMem[rdAddr];
        end
        rdDue  = ramRdEn;
        rdAddr = ramRdAddr;
        if (ramWrEn) begin
            if (expAddrQ.size() == 0) begin
                requireCond(tLoad, 1'b0, "RAM write with no expected result left");
            end else begin
                test = expTestQ.pop_front();
                addr = expAddrQ.pop_front();
                data = expDataQ.pop_front();
                compareValue(test, "ramWrAddr", ramWrAddr, addr);
                compareValue(test, "ramWrData", ramWrData, data);
            end
            ramMem[ramWrAddr] = ramWrData;
            wrCount++;
        end
    end

endmodule
